// ==== common/i2c_defs.svh ====
// clock divider and Wishbone register map for the I2C master

`ifndef I2C_DEFS_SVH
`define I2C_DEFS_SVH

// system clocks per quarter of an SCL bit
// SCL period is 4 * I2C_QUARTER_DIV clocks
`define I2C_QUARTER_DIV 5

// ----------------------------------------
// Wishbone register addresses (adr is 2 bits wide)
`define I2C_REG_TX     2'd0  // command, tx byte, tx ack bit
`define I2C_REG_STATUS 2'd1  // ready, valid, rx ack, busy
`define I2C_REG_RX     2'd2  // received byte, read clears valid

`endif

// ==== common/i2cPkg.sv ====
// shared types of the I2C master
// command and engine state enums, Wishbone and core structs

package i2cPkg;

    // command field of a TX write, dat bits 9..8
    typedef enum logic [1:0] {
        cmdStart    = 2'd0,  // start condition then byte
        cmdByte     = 2'd1,  // plain byte
        cmdByteStop = 2'd2,  // byte then stop condition
        cmdRestart  = 2'd3   // repeated start then byte
    } i2cCommand;

    // bit engine states
    typedef enum logic [2:0] {
        unitIdle   = 3'd0,  // bus released
        unitStartA = 3'd1,  // SDA low under high SCL
        unitStartB = 3'd2,  // SCL low after start
        unitBit    = 3'd3,  // eight data bits
        unitAck    = 3'd4,  // ninth bit
        unitStopA  = 3'd5,  // SCL up with SDA low
        unitStopB  = 3'd6,  // SDA up, stop condition
        unitDone   = 3'd7   // SCL held low, waiting for next byte
    } unitState;

    // ----------------------------------------
    // Wishbone classic request and response
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;
        logic [15:0] dat;
    } wbReqT;

    typedef struct packed {
        logic        ack;
        logic [15:0] dat;
    } wbRspT;

    // ----------------------------------------
    // host side of the core
    typedef struct packed {
        i2cCommand  command;
        logic [7:0] data;
        logic       ack;  // bit driven on the ninth clock
    } txReqT;

    typedef struct packed {
        logic [7:0] data;   // last received byte
        logic       ack;    // ack sampled on the ninth clock
        logic       valid;  // data not read yet
        logic       ready;  // tx register free
        logic       busy;   // engine in a transfer
    } rxStatusT;

endpackage

// ==== wishbone/i2cWbSlave.sv ====
// Wishbone classic slave for the I2C master
// register decode, TX write back-pressure, status formatting

`timescale 1ns/1ps
`include "i2c_defs.svh"

module i2cWbSlave (
    input  logic             clk,
    input  logic             reset,
    input  i2cPkg::wbReqT    wbReq,
    output i2cPkg::wbRspT    wbRsp,
    input  i2cPkg::rxStatusT rxStatus,
    output i2cPkg::txReqT    txReq,
    output logic             load,
    output logic             readReq
);

    logic        reqActive;   // cycle and strobe both up
    logic        txWrite;     // write to the TX register
    logic        otherReq;    // any other access, acked one cycle later
    logic        ackReg;      // registered ack of the other accesses
    logic        rxReadPend;  // ack in flight belongs to an RX read
    logic [15:0] datReg;      // read data

    assign reqActive = wbReq.cyc && wbReq.stb;
    assign txWrite   = reqActive && wbReq.we && (wbReq.adr == `I2C_REG_TX);
    // ackReg masks the request still on the bus in its ack cycle
    assign otherReq  = reqActive && !txWrite && !ackReg;

    // ----------------------------------------
    // TX write path

    // held off while the core still owns a byte
    assign load = txWrite && rxStatus.ready;

    // field split of the TX word
    assign txReq.command = i2cPkg::i2cCommand'(wbReq.dat[9:8]);
    assign txReq.data    = wbReq.dat[7:0];
    assign txReq.ack     = wbReq.dat[10];

    // ----------------------------------------
    // register reads and ignored accesses

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ackReg     <= 1'b0;
            rxReadPend <= 1'b0;
        end else begin
            ackReg     <= otherReq;
            rxReadPend <= otherReq && !wbReq.we && (wbReq.adr == `I2C_REG_RX);
        end
    end

    // status is captured when the strobe is seen
    always_ff @(posedge clk) begin
        if (otherReq) begin
            if (wbReq.we) begin
                datReg <= 16'd0;  // writes to status or rx do nothing
            end else begin
                case (wbReq.adr)
                    `I2C_REG_STATUS: datReg <= {12'd0, rxStatus.busy, rxStatus.ack,
                                                rxStatus.valid, rxStatus.ready};
                    `I2C_REG_RX:     datReg <= {8'd0, rxStatus.data};
                    default:         datReg <= 16'd0;  // TX and unused reads
                endcase
            end
        end
    end

    // TX writes ack in the load cycle, others one cycle after the strobe
    assign wbRsp.ack = ackReg || load;
    assign wbRsp.dat = datReg;

    assign readReq = rxReadPend;  // pulses together with the RX ack

endmodule

// ==== i2cCore/i2cClockUnit.sv ====
// quarter bit strobe generator for the I2C bit engine

`timescale 1ns/1ps
`include "i2c_defs.svh"

module i2cClockUnit (
    input  logic clk,
    input  logic reset,
    output logic dataCycle,
    output logic finalCycle
);

    localparam int DivWidth = $clog2(`I2C_QUARTER_DIV);
    localparam logic [DivWidth-1:0] DivLast = DivWidth'(`I2C_QUARTER_DIV - 1);

    logic [DivWidth-1:0] divCount;  // clocks inside a quarter
    logic [1:0]          quarter;   // quarter inside a bit

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            divCount <= '0;
            quarter  <= 2'd0;
        end else if (divCount == DivLast) begin
            divCount <= '0;
            quarter  <= quarter + 2'd1;  // wraps every four strobes
        end else begin
            divCount <= divCount + 1'b1;
        end
    end

    assign dataCycle  = (divCount == DivLast);
    assign finalCycle = dataCycle && (quarter == 2'd3);  // last quarter of the bit

endmodule

// ==== i2cCore/i2cUnit.sv ====
// I2C bit engine with start, byte, ack, stop and repeated start
// open-drain drivers for SCL and SDA

`timescale 1ns/1ps

module i2cUnit (
    input  logic          clk,
    input  logic          reset,
    input  logic          dataCycle,   // advance one quarter
    input  logic          finalCycle,  // fourth quarter of the divider
    input  i2cPkg::txReqT txReq,
    input  logic          txValid,
    output logic          txTaken,
    output logic [7:0]    rxByte,
    output logic          rxAck,
    output logic          rxDone,
    output logic          busy,
    inout  wire           scl,
    inout  wire           sda
);

    i2cPkg::unitState state;
    logic [1:0] qCnt;      // quarter inside a bit
    logic [2:0] bitCnt;    // data bit index, msb first
    logic [7:0] txShift;   // bits still to send in the top position
    logic [7:0] rxShift;   // line samples
    logic       txAckBit;  // value driven on the ninth bit
    logic       stopFlag;  // stop after this byte
    logic       sclOut;    // 1 releases the line
    logic       sdaOut;
    logic       isRestart;
    logic       sampleTick;

    // idle starts only on a divider boundary, done takes any quarter
    assign txTaken = txValid && ((state == i2cPkg::unitIdle && finalCycle) ||
                                 (state == i2cPkg::unitDone && dataCycle));

    // bus already owned, so a start from done becomes a repeated start
    assign isRestart = (txReq.command == i2cPkg::cmdStart) ||
                       (txReq.command == i2cPkg::cmdRestart);

    // SCL has been high for a full quarter here
    assign sampleTick = dataCycle && qCnt == 2'd1 &&
                        (state == i2cPkg::unitBit || state == i2cPkg::unitAck);

    // ----------------------------------------
    // control FSM
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state  <= i2cPkg::unitIdle;
            qCnt   <= 2'd0;
            bitCnt <= 3'd0;
            sclOut <= 1'b1;  // both lines released
            sdaOut <= 1'b1;
            rxDone <= 1'b0;
        end else begin
            rxDone <= 1'b0;
            if (dataCycle) begin
                case (state)
                    i2cPkg::unitIdle: begin
                        if (txTaken) begin  // every command from idle opens with a start
                            sdaOut <= 1'b0;   // SDA falls under high SCL
                            qCnt   <= 2'd1;
                            state  <= i2cPkg::unitStartA;
                        end
                    end
                    i2cPkg::unitDone: begin
                        if (txTaken && isRestart) begin
                            sclOut <= 1'b1;  // SDA already released
                            qCnt   <= 2'd0;
                            state  <= i2cPkg::unitStartA;
                        end else if (txTaken) begin
                            sdaOut <= txReq.data[7];
                            qCnt   <= 2'd0;
                            bitCnt <= 3'd0;
                            state  <= i2cPkg::unitBit;
                        end
                    end
                    i2cPkg::unitStartA: begin
                        if (qCnt == 2'd0) begin
                            sdaOut <= 1'b0;  // repeated start edge
                            qCnt   <= 2'd1;
                        end else begin
                            sclOut <= 1'b0;
                            state  <= i2cPkg::unitStartB;
                        end
                    end
                    i2cPkg::unitStartB: begin
                        sdaOut <= txShift[7];  // first data bit under low SCL
                        qCnt   <= 2'd0;
                        bitCnt <= 3'd0;
                        state  <= i2cPkg::unitBit;
                    end
                    i2cPkg::unitBit, i2cPkg::unitAck: begin
                        qCnt <= qCnt + 2'd1;
                        case (qCnt)
                            2'd0: sclOut <= 1'b1;  // rising edge
                            2'd2: sclOut <= 1'b0;  // falling edge
                            2'd3: begin
                                if (state == i2cPkg::unitAck) begin
                                    rxDone <= 1'b1;
                                    sdaOut <= !stopFlag;  // low ahead of a stop
                                    state  <= stopFlag ? i2cPkg::unitStopA
                                                       : i2cPkg::unitDone;
                                end else if (bitCnt == 3'd7) begin
                                    sdaOut <= txAckBit;
                                    state  <= i2cPkg::unitAck;
                                end else begin
                                    sdaOut <= txShift[6];  // next bit
                                    bitCnt <= bitCnt + 3'd1;
                                end
                            end
                            default: ;  // sample quarter, see datapath
                        endcase
                    end
                    i2cPkg::unitStopA: begin
                        sclOut <= 1'b1;
                        state  <= i2cPkg::unitStopB;
                    end
                    default: begin  // unitStopB
                        sdaOut <= 1'b1;  // SDA rises under high SCL
                        state  <= i2cPkg::unitIdle;
                    end
                endcase
            end
        end
    end

    // ----------------------------------------
    // shift registers and byte options
    always_ff @(posedge clk) begin
        if (txTaken) begin
            txShift  <= txReq.data;
            txAckBit <= txReq.ack;
            stopFlag <= (txReq.command == i2cPkg::cmdByteStop);
        end else if (dataCycle && state == i2cPkg::unitBit && qCnt == 2'd3) begin
            txShift <= {txShift[6:0], 1'b0};
        end
        if (sampleTick && state == i2cPkg::unitBit)
            rxShift <= {rxShift[6:0], sda};
        if (sampleTick && state == i2cPkg::unitAck)
            rxAck <= sda;
    end

    assign rxByte = rxShift;
    assign busy   = (state != i2cPkg::unitIdle) && (state != i2cPkg::unitDone);

    // open-drain pins, low or released
    assign scl = sclOut ? 1'bz : 1'b0;
    assign sda = sdaOut ? 1'bz : 1'b0;

endmodule

// ==== i2cCore/i2cCore.sv ====
// I2C master core with the host visible registers and flags
// holds one byte for the bit engine and one received byte for the host

`timescale 1ns/1ps

module i2cCore (
    input  logic             clk,
    input  logic             reset,
    input  i2cPkg::txReqT    txReq,
    input  logic             load,
    input  logic             readReq,
    output i2cPkg::rxStatusT rxStatus,
    inout  wire              scl,
    inout  wire              sda
);

    logic          dataCycle;   // quarter bit strobe
    logic          finalCycle;  // fourth quarter strobe
    logic          txTaken;     // engine captured the stored byte
    logic          rxDone;      // engine finished the ninth bit
    logic [7:0]    unitByte;    // byte shifted in by the engine
    logic          unitAck;     // ack sampled by the engine
    logic          unitBusy;

    i2cPkg::txReqT txStore;     // byte waiting for the engine
    logic          txReady;     // txStore free for the host
    logic          rxValid;     // rxData not yet read
    logic [7:0]    rxData;
    logic          rxAck;

    // ----------------------------------------
    // transmit side

    // command, byte and ack bit together
    always_ff @(posedge clk) begin
        if (load)
            txStore <= txReq;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            txReady <= 1'b1;
        else if (load)
            txReady <= 1'b0;  // load beats txTaken in the same cycle
        else if (txTaken)
            txReady <= 1'b1;  // engine has its own copy now
    end

    // ----------------------------------------
    // receive side

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rxData <= 8'd0;
            rxAck  <= 1'b1;   // no ack seen yet
        end else if (rxDone) begin
            rxData <= unitByte;
            rxAck  <= unitAck;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            rxValid <= 1'b0;
        else if (rxDone)
            rxValid <= 1'b1;  // new byte beats a read in the same cycle
        else if (readReq)
            rxValid <= 1'b0;
    end

    assign rxStatus.data  = rxData;
    assign rxStatus.ack   = rxAck;
    assign rxStatus.valid = rxValid;
    assign rxStatus.ready = txReady;
    assign rxStatus.busy  = unitBusy;

    // ----------------------------------------
    // bit engine and its strobes

    i2cUnit unit_i (
        .clk,
        .reset,
        .dataCycle,
        .finalCycle,
        .txReq   (txStore),
        .txValid (!txReady),  // a byte is waiting
        .txTaken,
        .rxByte  (unitByte),
        .rxAck   (unitAck),
        .rxDone,
        .busy    (unitBusy),
        .scl,
        .sda
    );

    i2cClockUnit clockUnit_i (
        .clk,
        .reset,
        .dataCycle,
        .finalCycle
    );

endmodule

// ==== design/i2cTop.sv ====
// I2C master top with Wishbone slave and core on the bus pins

`timescale 1ns/1ps

module i2cTop (
    input  logic          clk,
    input  logic          reset,
    input  i2cPkg::wbReqT wbReq,
    output i2cPkg::wbRspT wbRsp,
    inout  wire           scl,
    inout  wire           sda
);

    i2cPkg::txReqT    txReq;     // TX word split into fields
    i2cPkg::rxStatusT rxStatus;  // flags and received byte
    logic             load;      // TX register write
    logic             readReq;   // RX register read

    i2cWbSlave wbSlave_i (
        .clk,
        .reset,
        .wbReq,
        .wbRsp,
        .rxStatus,
        .txReq,
        .load,
        .readReq
    );

    i2cCore core_i (
        .clk,
        .reset,
        .txReq,
        .load,
        .readReq,
        .rxStatus,
        .scl,
        .sda
    );

endmodule

// ==== verification/tbClock.sv ====
// testbench clock and reset source, 20 ns period

`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        reset = 1'b1;  // held for three rising edges
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
    end

endmodule

// ==== verification/i2cMemSlave.sv ====
// behavioral I2C memory slave at address 0x50
// one pointer byte after the address, auto-incrementing on every byte

`timescale 1ns/1ps

module i2cMemSlave (
    inout wire scl,
    inout wire sda
);

    localparam logic [6:0] DevAddr = 7'h50;

    logic [7:0] mem [0:255];
    logic [7:0] shiftIn;    // bits from the master
    logic [7:0] shiftOut;   // byte being returned
    logic [7:0] pointer;
    int         bitCount;   // 0..9 inside a byte frame
    logic       sdaLow;     // 1 pulls SDA down
    logic       addrPhase;  // next byte is the device address
    logic       ptrPhase;   // next write byte is the pointer
    logic       selected;
    logic       reading;
    logic       fromAddr;   // first read byte right after the address
    logic       masterAck;

    assign sda = sdaLow ? 1'b0 : 1'bz;

    initial begin
        for (int i = 0; i < 256; i++)
            mem[i] = 8'(i * 7 + 8'h3C);  // fill varies with every address bit
        shiftIn   = 8'd0;
        shiftOut  = 8'hFF;
        pointer   = 8'd0;
        bitCount  = 0;
        sdaLow    = 1'b0;
        addrPhase = 1'b0;
        ptrPhase  = 1'b0;
        selected  = 1'b0;
        reading   = 1'b0;
        fromAddr  = 1'b0;
        masterAck = 1'b0;
    end

    // ----------------------------------------
    // start and stop conditions
    always @(negedge sda) begin
        if (scl === 1'b1) begin  // start or repeated start
            bitCount  = 0;
            addrPhase = 1'b1;
            selected  = 1'b0;
            reading   = 1'b0;
            sdaLow    = 1'b0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1) begin  // stop
            addrPhase = 1'b0;
            selected  = 1'b0;
            sdaLow    = 1'b0;
        end
    end

    // ----------------------------------------
    // bit sampling on the rising edge
    always @(posedge scl) begin
        if (addrPhase || selected) begin
            if (bitCount < 8)
                shiftIn = {shiftIn[6:0], (sda === 1'b0) ? 1'b0 : 1'b1};
            else if (reading)
                masterAck = (sda === 1'b0);
            bitCount++;
        end
    end

    // line changes only while SCL is low
    always @(negedge scl) begin
        if (bitCount == 8) begin  // ninth bit slot begins
            if (addrPhase) begin
                addrPhase = 1'b0;
                selected  = (shiftIn[7:1] == DevAddr);
                reading   = shiftIn[0];
                ptrPhase  = !shiftIn[0];
                fromAddr  = shiftIn[0];
                sdaLow    = (shiftIn[7:1] == DevAddr);  // ack only our address
            end else if (selected && !reading) begin
                if (ptrPhase) begin
                    pointer  = shiftIn;
                    ptrPhase = 1'b0;
                end else begin
                    mem[pointer] = shiftIn;
                    pointer++;
                end
                sdaLow = 1'b1;
            end else begin
                sdaLow = 1'b0;  // master owns the ack of a read byte
            end
        end else if (bitCount == 9) begin
            bitCount = 0;
            sdaLow   = 1'b0;
            if (selected && reading) begin
                if (fromAddr) begin
                    fromAddr = 1'b0;
                    shiftOut = mem[pointer];
                    sdaLow   = !shiftOut[7];
                end else if (masterAck) begin
                    pointer++;
                    shiftOut = mem[pointer];
                    sdaLow   = !shiftOut[7];
                end else begin
                    selected = 1'b0;  // nack ends the read
                end
            end
        end else if (selected && reading && bitCount >= 1 && bitCount <= 7) begin
            sdaLow = !shiftOut[7 - bitCount];
        end
    end

endmodule

// ==== verification/i2c_chk.sv ====
// protocol assertions bound to the I2C master top

`timescale 1ns/1ps

module i2cChk (
    input logic             clk,
    input logic             reset,
    input i2cPkg::wbReqT    wbReq,
    input i2cPkg::wbRspT    wbRsp,
    input logic             load,
    input logic             ready,
    input wire              scl,
    input wire              sda,
    input i2cPkg::unitState state
);

    logic violated;  // any protocol assertion has failed

    initial violated = 1'b0;

    // SDA may move under high SCL only for start and stop
    sdaHold: assert property (@(posedge clk) disable iff (reset)
        (scl === 1'b1 && $past(scl) === 1'b1 && sda !== $past(sda)) |->
        ($past(state) inside {i2cPkg::unitIdle, i2cPkg::unitStartA, i2cPkg::unitStopB}))
        else begin
            $error("SDA changed while SCL was high outside a start or stop");
            violated = 1'b1;
        end

    ackInCycle: assert property (@(posedge clk) disable iff (reset)
        wbRsp.ack |-> (wbReq.cyc && wbReq.stb))
        else begin
            $error("Wishbone ack without cyc and stb");
            violated = 1'b1;
        end

    // a load needs a free TX register and then owns it
    loadWhenReady: assert property (@(posedge clk) disable iff (reset)
        load |-> ready ##1 !ready)
        else begin
            $error("TX load while the TX register was full, or ready not cleared by it");
            violated = 1'b1;
        end

endmodule

bind i2cTop i2cChk chk_i (
    .clk,
    .reset,
    .wbReq,
    .wbRsp,
    .load,
    .ready (rxStatus.ready),
    .scl,
    .sda,
    .state (core_i.unit_i.state)
);

// ==== verification/i2cTb.sv ====
// testbench top for the I2C master
// Wishbone tasks, memory mirror, compare process and timeout

`timescale 1ns/1ps
`include "i2c_defs.svh"

module i2cTb;

    localparam int TimeoutCycles = 60 * 40 * 5 * 2;  // 60 bytes, 40 quarters, 2x margin

    logic          clk;
    logic          reset;
    i2cPkg::wbReqT wbReq;
    i2cPkg::wbRspT wbRsp;
    wire           scl;
    wire           sda;

    logic [7:0]    mirror [0:255];  // what the slave memory should hold
    logic [15:0]   gotQ [$];
    logic [15:0]   expQ [$];
    string         whatQ [$];
    logic [15:0]   cmpGot;
    logic [15:0]   cmpExp;
    string         cmpWhat;
    int            cycleCount;
    integer        seed;

    pullup (scl);
    pullup (sda);

    tbClock clock_i (.clk, .reset);

    i2cTop dut_i (.clk, .reset, .wbReq, .wbRsp, .scl, .sda);

    i2cMemSlave mem_i (.scl, .sda);

    // ----------------------------------------
    // reference and compare

    function automatic logic [7:0] expectedRead(input logic [7:0] addr);
        return mirror[addr];
    endfunction

    task automatic expectEqual(input logic [15:0] got, input logic [15:0] exp,
                               input string what);
        gotQ.push_back(got);
        expQ.push_back(exp);
        whatQ.push_back(what);
    endtask

    always @(negedge clk) begin
        while (gotQ.size() > 0) begin
            cmpGot  = gotQ.pop_front();
            cmpExp  = expQ.pop_front();
            cmpWhat = whatQ.pop_front();
            assert (cmpGot === cmpExp) else begin
                $display("[ERROR] %0t %s: got %h expected %h", $time, cmpWhat, cmpGot, cmpExp);
                $display("test failed");
                $fatal(1, "first mismatch ends the run");
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TimeoutCycles) begin
            $display("run did not finish within %0d clock cycles", TimeoutCycles);
            $display("test failed");
            $fatal(1, "timeout");
        end
    end

    // bound protocol checker
    always @(posedge dut_i.chk_i.violated) begin
        $display("a bus protocol assertion failed at %0t", $time);
        $display("test failed");
        $fatal(1, "protocol violation");
    end

    // ----------------------------------------
    // Wishbone access, entered and left 1 ns after a rising edge
    task automatic wbAccess(input logic we, input logic [1:0] adr, input logic [15:0] dat,
                            output logic [15:0] rdat, output int waited);
        waited    = 0;
        wbReq.cyc = 1'b1;
        wbReq.stb = 1'b1;
        wbReq.we  = we;
        wbReq.adr = adr;
        wbReq.dat = dat;
        @(negedge clk);
        while (!wbRsp.ack) begin  // TX writes stall here while full
            waited++;
            @(negedge clk);
        end
        rdat = wbRsp.dat;
        @(posedge clk);
        #1;
        wbReq.cyc = 1'b0;
        wbReq.stb = 1'b0;
        wbReq.we  = 1'b0;
    endtask

    task automatic sendByte(input i2cPkg::i2cCommand cmd, input logic [7:0] data,
                            input logic txAck, output int waited);
        logic [15:0] rd;
        wbAccess(1'b1, `I2C_REG_TX, {5'd0, txAck, cmd, data}, rd, waited);
    endtask

    task automatic readStatus(output logic [15:0] rd);
        int w;
        wbAccess(1'b0, `I2C_REG_STATUS, 16'd0, rd, w);
    endtask

    // poll for valid, then check ack, data and the cleared flag
    task automatic collectByte(input logic [7:0] expData, input logic expAck,
                               input string what);
        logic [15:0] rd;
        int          w;
        rd = 16'd0;
        while (!rd[1])
            readStatus(rd);
        expectEqual({15'd0, rd[2]}, {15'd0, expAck}, {what, " ack"});
        wbAccess(1'b0, `I2C_REG_RX, 16'd0, rd, w);
        expectEqual(rd, {8'd0, expData}, {what, " data"});
        readStatus(rd);
        expectEqual({15'd0, rd[1]}, 16'd0, {what, " valid after RX read"});
    endtask

    // ----------------------------------------
    // stimulus
    initial begin
        logic [15:0] rd;
        logic [7:0]  data [0:7];
        logic [7:0]  pointer;
        logic        last;
        int          w;

        wbReq      = '0;
        cycleCount = 0;
        seed       = 93;
        pointer    = 8'h20;
        for (int i = 0; i < 256; i++)
            mirror[i] = 8'd0;
        @(negedge reset);
        @(posedge clk);
        #1;

        // state after reset
        readStatus(rd);
        expectEqual(rd, 16'h0005, "status after reset");
        expectEqual({14'd0, scl, sda}, 16'd3, "bus pins after reset");

        // write burst, first two data bytes back to back
        sendByte(i2cPkg::cmdStart, 8'hA0, 1'b1, w);
        collectByte(8'hA0, 1'b0, "write address");
        sendByte(i2cPkg::cmdByte, pointer, 1'b1, w);
        collectByte(pointer, 1'b0, "pointer");
        for (int i = 0; i < 8; i++)
            data[i] = 8'($random(seed));
        sendByte(i2cPkg::cmdByte, data[0], 1'b1, w);
        sendByte(i2cPkg::cmdByte, data[1], 1'b1, w);
        expectEqual(16'(w > 0), 16'd1, "second TX write held until ready");
        readStatus(rd);
        expectEqual({15'd0, rd[3]}, 16'd1, "busy during transfer");
        collectByte(data[0], 1'b0, "write byte 0");
        collectByte(data[1], 1'b0, "write byte 1");
        for (int i = 2; i < 8; i++) begin
            last = (i == 7);
            sendByte(last ? i2cPkg::cmdByteStop : i2cPkg::cmdByte, data[i], 1'b1, w);
            collectByte(data[i], 1'b0, "write byte");
        end
        for (int i = 0; i < 8; i++)
            mirror[8'(pointer + i)] = data[i];

        // read back through a repeated start
        sendByte(i2cPkg::cmdStart, 8'hA0, 1'b1, w);
        collectByte(8'hA0, 1'b0, "read setup address");
        sendByte(i2cPkg::cmdByte, pointer, 1'b1, w);
        collectByte(pointer, 1'b0, "read pointer");
        sendByte(i2cPkg::cmdRestart, 8'hA1, 1'b1, w);
        collectByte(8'hA1, 1'b0, "read address");
        for (int i = 0; i < 8; i++) begin
            last = (i == 7);
            sendByte(last ? i2cPkg::cmdByteStop : i2cPkg::cmdByte, 8'hFF, last, w);
            collectByte(expectedRead(8'(pointer + i)), last, "read byte");
        end

        // nobody answers 0x84
        sendByte(i2cPkg::cmdByteStop, 8'h84, 1'b1, w);
        collectByte(8'h84, 1'b1, "wrong address");
        rd = 16'hFFFF;
        while (rd[3])
            readStatus(rd);
        expectEqual({14'd0, scl, sda}, 16'd3, "bus released after stop");

        while (gotQ.size() != 0)
            @(negedge clk);
        @(posedge clk);
        #1;
        $display("test passed");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+common
common/i2cPkg.sv
wishbone/i2cWbSlave.sv
i2cCore/i2cClockUnit.sv
i2cCore/i2cUnit.sv
i2cCore/i2cCore.sv
design/i2cTop.sv
verification/tbClock.sv
verification/i2cMemSlave.sv
verification/i2c_chk.sv
verification/i2cTb.sv

// ==== Bender.yml ====
package:
  name: i2c_master

sources:
  - include_dirs:
      - common
    files:
      - common/i2cPkg.sv
      - wishbone/i2cWbSlave.sv
      - i2cCore/i2cClockUnit.sv
      - i2cCore/i2cUnit.sv
      - i2cCore/i2cCore.sv
      - design/i2cTop.sv
      - target: test
        files:
          - verification/tbClock.sv
          - verification/i2cMemSlave.sv
          - verification/i2c_chk.sv
          - verification/i2cTb.sv
